// ==== verilog/systolic_pkg.sv ====
package systolic_pkg;

    // ==============================
    // Widths and array shape
    // ==============================

    // One matrix element
    localparam int DATA_W = 16;

    // Products and partial sums
    localparam int ACC_W = 40;

    // Rows and columns of the PE grid
    localparam int ARRAY_DIM = 4;

    // ==============================
    // Feed phase timing
    // ==============================

    // Last feed count of a full size job
    localparam int FEED_LAST = 2 * ARRAY_DIM + 2;

    // First anti-diagonal sum visible at the bottom row
    localparam int SUM_FIRST = ARRAY_DIM;

    // Vector types
    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [ACC_W-1:0]             acc_t;
    typedef logic [$clog2(ARRAY_DIM)-1:0] idx_t;
    typedef logic [5:0]                   count_t;

    // Loader sequencing
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        FEED
    } loader_state_e;

endpackage

// ==== verilog/operand_if.sv ====
`timescale 1ns/10ps

interface operand_if import systolic_pkg::*; ();

    // Start of job, zeroes the whole grid
    logic  clear;

    // Stationary weight write port
    logic  wt_we;
    idx_t  wt_row;
    idx_t  wt_col;
    data_t wt_data;

    // Skewed input per array row, zero is a bubble
    data_t x_row [ARRAY_DIM];

    modport loader (
        output clear,
        output wt_we,
        output wt_row,
        output wt_col,
        output wt_data,
        output x_row
    );

    modport array (
        input clear,
        input wt_we,
        input wt_row,
        input wt_col,
        input wt_data,
        input x_row
    );

endinterface

// ==== verilog/operand_loader.sv ====
`timescale 1ns/10ps

module operand_loader import systolic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  data_t     matrix,
    input  logic      matrix_size,
    operand_if.loader ops,
    output logic      sum_window
);

    loader_state_e state;
    count_t        count;
    logic          size_4x4;

    // Size dependent limits
    count_t dim;
    count_t nn;
    count_t load_last;
    count_t feed_last;

    // Position of the incoming word
    count_t word_idx;
    count_t elem;
    logic   is_weight;
    idx_t   elem_row;
    idx_t   elem_col;

    // X operand held for the feed phase
    data_t  x_store [ARRAY_DIM][ARRAY_DIM];
    count_t feed_row [ARRAY_DIM];

    // ==============================
    // Size decode
    // ==============================

    assign dim       = size_4x4 ? count_t'(ARRAY_DIM) : count_t'(ARRAY_DIM / 2);
    assign nn        = size_4x4 ? count_t'(ARRAY_DIM * ARRAY_DIM)
                                : count_t'(ARRAY_DIM * ARRAY_DIM / 4);
    // 2*N*N - 2 words after the first one
    assign load_last = nn + nn - count_t'(2);
    // Half size job ends 2N counts earlier
    assign feed_last = size_4x4 ? count_t'(FEED_LAST) : count_t'(FEED_LAST - ARRAY_DIM);

    // ==============================
    // Word routing
    // ==============================

    // Word 0 arrives in IDLE, so LOAD count n carries word n+1
    assign word_idx  = count + count_t'(1);
    assign is_weight = word_idx < nn;
    assign elem      = is_weight ? word_idx : word_idx - nn;

    // Row-major split of the element index
    assign elem_row = size_4x4 ? idx_t'(elem[3:2]) : idx_t'(elem[1]);
    assign elem_col = size_4x4 ? idx_t'(elem[1:0]) : idx_t'(elem[0]);

    // Job start clears the grid and writes W[0][0] in one cycle
    assign ops.clear   = (state == IDLE) && in_valid;
    assign ops.wt_we   = ops.clear || ((state == LOAD) && is_weight);
    assign ops.wt_row  = (state == LOAD) ? elem_row : '0;
    assign ops.wt_col  = (state == LOAD) ? elem_col : '0;
    assign ops.wt_data = matrix;

    // X words
    always_ff @(posedge clk) begin
        if ((state == LOAD) && !is_weight) begin
            x_store[elem_row][elem_col] <= matrix;
        end
    end

    // ==============================
    // Sequencing FSM
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            count    <= '0;
            size_4x4 <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        size_4x4 <= matrix_size;
                        count    <= '0;
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    if (count == load_last) begin
                        count <= '0;
                        state <= FEED;
                    end else begin
                        count <= count + count_t'(1);
                    end
                end
                FEED: begin
                    // Done after the last anti-diagonal has been sampled
                    if (count == feed_last) begin
                        count <= '0;
                        state <= IDLE;
                    end else begin
                        count <= count + count_t'(1);
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Diagonal skew
    // ==============================

    // Row j gets X[n-j][j], so it starts j counts late
    always_comb begin
        for (int j = 0; j < ARRAY_DIM; j++) begin
            feed_row[j] = count - count_t'(j);
            if ((state == FEED) && (count >= count_t'(j)) &&
                (feed_row[j] < dim) && (count_t'(j) < dim)) begin
                ops.x_row[j] = x_store[idx_t'(feed_row[j])][j];
            end else begin
                ops.x_row[j] = '0;
            end
        end
    end

    // Bottom row holds a complete anti-diagonal
    assign sum_window = (state == FEED) && (count >= count_t'(SUM_FIRST)) &&
                        (count <= feed_last);

endmodule

// ==== verilog/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array import systolic_pkg::*; (
    input  logic     clk,
    operand_if.array ops,
    output acc_t     col_sum [ARRAY_DIM]
);

    // Stationary weights, one per PE
    data_t w [ARRAY_DIM][ARRAY_DIM];

    // Horizontal input pipeline
    // Last column has no right neighbour, hence one stage less
    data_t xs [ARRAY_DIM][ARRAY_DIM-1];

    // Accumulating partial sums, flowing downward
    acc_t  ps [ARRAY_DIM][ARRAY_DIM];

    // ==============================
    // PE grid
    // ==============================

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col

            data_t pe_in;
            acc_t  ps_above;
            logic  wt_hit;

            // Input from the left edge or the neighbour stage
            if (c == 0) begin : g_edge_in
                assign pe_in = ops.x_row[r];
            end else begin : g_chain_in
                assign pe_in = xs[r][c-1];
            end

            // Top row starts from zero
            if (r == 0) begin : g_top
                assign ps_above = '0;
            end else begin : g_inner
                assign ps_above = ps[r-1][c];
            end

            assign wt_hit = ops.wt_we && (ops.wt_row == idx_t'(r)) &&
                            (ops.wt_col == idx_t'(c));

            // Weight register
            // A write in the clear cycle still lands
            always_ff @(posedge clk) begin
                if (ops.clear) begin
                    w[r][c] <= wt_hit ? ops.wt_data : '0;
                end else if (wt_hit) begin
                    w[r][c] <= ops.wt_data;
                end
            end

            // Multiply-accumulate
            always_ff @(posedge clk) begin
                if (ops.clear) begin
                    ps[r][c] <= '0;
                end else begin
                    ps[r][c] <= ps_above + acc_t'(w[r][c]) * acc_t'(pe_in);
                end
            end

            // Pass the input one column right
            if (c < ARRAY_DIM - 1) begin : g_shift
                always_ff @(posedge clk) begin
                    if (ops.clear) begin
                        xs[r][c] <= '0;
                    end else begin
                        xs[r][c] <= pe_in;
                    end
                end
            end

        end
    end

    // ==============================
    // Bottom row taps
    // ==============================

    // Column c of diagonal k shows up at feed count k+4
    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_tap
        assign col_sum[c] = ps[ARRAY_DIM-1][c];
    end

endmodule

// ==== verilog/diagonal_collector.sv ====
`timescale 1ns/10ps

module diagonal_collector import systolic_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  acc_t col_sum [ARRAY_DIM],
    input  logic sum_window,
    output logic out_valid,
    output acc_t out_value
);

    // Anti-diagonal total across the bottom row
    acc_t diag_sum;

    // ==============================
    // Column adder
    // ==============================

    always_comb begin
        diag_sum = '0;
        for (int c = 0; c < ARRAY_DIM; c++) begin
            diag_sum = diag_sum + col_sum[c];
        end
    end

    // Output stage, one cycle behind the window
    // Value forced to zero outside the window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_value <= '0;
        end else begin
            out_valid <= sum_window;
            if (sum_window) begin
                out_value <= diag_sum;
            end else begin
                out_value <= '0;
            end
        end
    end

endmodule

// ==== verilog/systolic_matmul.sv ====
`timescale 1ns/10ps

module systolic_matmul import systolic_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  data_t matrix,
    input  logic  matrix_size,
    output logic  out_valid,
    output acc_t  out_value
);

    // ==============================
    // Internal links
    // ==============================

    // Loader to array operands
    operand_if i_ops ();

    // Bottom row partial sums
    acc_t col_sum [ARRAY_DIM];

    // Valid anti-diagonal at the bottom row
    logic sum_window;

    // ==============================
    // Input side
    // ==============================

    operand_loader i_operand_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .matrix      (matrix),
        .matrix_size (matrix_size),
        .ops         (i_ops),
        .sum_window  (sum_window)
    );

    // PE grid
    systolic_array i_systolic_array (
        .clk     (clk),
        .ops     (i_ops),
        .col_sum (col_sum)
    );

    // Output side
    diagonal_collector i_diagonal_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_sum    (col_sum),
        .sum_window (sum_window),
        .out_valid  (out_valid),
        .out_value  (out_value)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== testbench/systolic_matmul_asserts.sv ====
`timescale 1ns/10ps

module systolic_matmul_asserts import systolic_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic out_valid,
    input acc_t out_value
);

    // Cycles out_valid has already been high in a row
    logic [3:0] high_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            high_cnt <= '0;
        end else if (!out_valid) begin
            high_cnt <= '0;
        end else if (high_cnt != 4'hf) begin
            high_cnt <= high_cnt + 4'd1;
        end
    end

    // No result value outside a run
    a_quiet_value: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_value == '0))
        else $error("out_value is nonzero while out_valid is low");

    // Longest run belongs to a 4x4 job
    a_run_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (high_cnt < 4'd7))
        else $error("out_valid stayed high for more than 7 cycles");

    // Output idle in reset
    a_reset_idle: assert property (@(negedge clk) !rst_n |-> !out_valid)
        else $error("out_valid is high while rst_n is low");

endmodule

bind systolic_matmul systolic_matmul_asserts i_systolic_matmul_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_value (out_value)
);

// ==== testbench/tb_systolic_matmul.sv ====
`timescale 1ns/10ps

module tb_systolic_matmul import systolic_pkg::*; ();

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    data_t matrix;
    logic  matrix_size;
    logic  out_valid;
    acc_t  out_value;

    // Operands of the job being built
    data_t w_mat [ARRAY_DIM][ARRAY_DIM];
    data_t x_mat [ARRAY_DIM][ARRAY_DIM];

    // Expected sums and last word cycle, one entry set per job
    acc_t  expected [$];
    int    last_words [$];

    // Runs seen by the output monitor
    acc_t  got_values [$];
    int    run_lens [$];
    int    run_starts [$];
    int    run_len = 0;
    int    run_start = 0;

    int    cycle_cnt = 0;
    int    value_errors = 0;
    int    other_errors = 0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    systolic_matmul i_systolic_matmul (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .matrix      (matrix),
        .matrix_size (matrix_size),
        .out_valid   (out_valid),
        .out_value   (out_value)
    );

    // Cycle number, cycle i starts at rising edge i
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ==============================
    // Output monitor
    // ==============================

    always @(negedge clk) begin
        if (!out_valid && (out_value != '0)) begin
            $display("FAIL out_value: got %h while out_valid low, expected %h",
                     out_value, acc_t'(0));
            value_errors++;
        end
        if (rst_n && out_valid) begin
            if (run_len == 0) begin
                run_start = cycle_cnt;
            end
            run_len++;
            got_values.push_back(out_value);
        end else if (run_len != 0) begin
            run_lens.push_back(run_len);
            run_starts.push_back(run_start);
            run_len = 0;
        end
    end

    // Anti-diagonal k of P = X*W, terms inside the n x n matrix only
    function automatic acc_t diag_sum(input int n, input int k);
        acc_t sum;
        int   i;
        sum = '0;
        for (int c = 0; c < n; c++) begin
            i = k - c;
            if ((i >= 0) && (i < n)) begin
                for (int t = 0; t < n; t++) begin
                    sum += acc_t'(x_mat[idx_t'(i)][idx_t'(t)]) *
                           acc_t'(w_mat[idx_t'(t)][idx_t'(c)]);
                end
            end
        end
        return sum;
    endfunction

    // Operands, random or one constant
    task automatic fill_operands(input int n, input bit random, input data_t value);
        for (int r = 0; r < ARRAY_DIM; r++) begin
            for (int c = 0; c < ARRAY_DIM; c++) begin
                w_mat[idx_t'(r)][idx_t'(c)] = '0;
                x_mat[idx_t'(r)][idx_t'(c)] = '0;
                if ((r < n) && (c < n)) begin
                    w_mat[idx_t'(r)][idx_t'(c)] = random ? data_t'($urandom) : value;
                    x_mat[idx_t'(r)][idx_t'(c)] = random ? data_t'($urandom) : value;
                end
            end
        end
    endtask

    // ==============================
    // Stimulus and checks
    // ==============================

    // W then X in row-major order, one word per cycle
    task automatic send_job(input int n);
        int e;
        for (int k = 0; k < 2 * n - 1; k++) begin
            expected.push_back(diag_sum(n, k));
        end
        for (int i = 0; i < 2 * n * n; i++) begin
            e = i % (n * n);
            @(posedge clk);
            in_valid    <= 1'b1;
            matrix_size <= (n == ARRAY_DIM);
            if (i < n * n) begin
                matrix <= w_mat[idx_t'(e / n)][idx_t'(e % n)];
            end else begin
                matrix <= x_mat[idx_t'(e / n)][idx_t'(e % n)];
            end
        end
        last_words.push_back(cycle_cnt + 1);
    endtask

    task automatic drop_inputs();
        @(posedge clk);
        in_valid    <= 1'b0;
        matrix      <= '0;
        matrix_size <= 1'b0;
    endtask

    // Next rising edge starts cycle target
    task automatic align_to_cycle(input int target);
        int waited;
        waited = 0;
        @(posedge clk);
        while ((cycle_cnt + 2 < target) && (waited < 100)) begin
            @(posedge clk);
            waited++;
        end
        if (cycle_cnt + 2 != target) begin
            $display("Could not line up the next job with cycle %0d", target);
            other_errors++;
        end
    endtask

    // Oldest job. Run length, start offset and each value
    task automatic check_run(input int n);
        int   waited;
        int   len;
        int   start;
        int   offset;
        acc_t got;
        acc_t want;
        waited = 0;
        while ((run_lens.size() == 0) && (waited < 100)) begin
            @(posedge clk);
            waited++;
        end
        if (run_lens.size() == 0) begin
            $display("Timed out waiting for the out_valid run of a %0dx%0d job", n, n);
            other_errors++;
            expected.delete();
            last_words.delete();
            got_values.delete();
            return;
        end
        len    = run_lens.pop_front();
        start  = run_starts.pop_front();
        offset = start - last_words.pop_front();
        if (len != 2 * n - 1) begin
            $display("FAIL out_valid length: got %h, expected %h", len, 2 * n - 1);
            other_errors++;
        end
        if (offset != 6) begin
            $display("FAIL out_valid start: got %h cycles after last word, expected %h",
                     offset, 6);
            other_errors++;
        end
        for (int k = 0; k < 2 * n - 1; k++) begin
            want = expected.pop_front();
            if (k < len) begin
                got = got_values.pop_front();
                if (got != want) begin
                    $display("FAIL out_value: diagonal %0d got %h, expected %h", k, got, want);
                    value_errors++;
                end
            end
        end
        while (len > 2 * n - 1) begin
            void'(got_values.pop_front());
            len--;
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_quiet_output();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (out_valid || (out_value != '0)) begin
                $display("FAIL out_valid/out_value after reset: got %h/%h, expected 0/0",
                         out_valid, out_value);
                other_errors++;
            end
        end
    endtask

    // W = [1 2; 3 4], X = [5 6; 7 8]
    task automatic test_known_2x2();
        fill_operands(2, 1'b0, '0);
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 2; c++) begin
                w_mat[idx_t'(r)][idx_t'(c)] = data_t'(1 + 2 * r + c);
                x_mat[idx_t'(r)][idx_t'(c)] = data_t'(5 + 2 * r + c);
            end
        end
        send_job(2);
        drop_inputs();
        check_run(2);
    endtask

    // Random data, then all ones for the widest products
    task automatic test_random_4x4();
        fill_operands(ARRAY_DIM, 1'b1, '0);
        send_job(ARRAY_DIM);
        drop_inputs();
        check_run(ARRAY_DIM);
        fill_operands(ARRAY_DIM, 1'b0, 16'hffff);
        send_job(ARRAY_DIM);
        drop_inputs();
        check_run(ARRAY_DIM);
    endtask

    // 2x2 job starts in the last out_valid cycle of a 4x4 job
    task automatic test_back_to_back();
        fill_operands(ARRAY_DIM, 1'b1, '0);
        send_job(ARRAY_DIM);
        drop_inputs();
        fill_operands(2, 1'b1, '0);
        align_to_cycle(last_words[$] + 6 + 2 * ARRAY_DIM - 2);
        send_job(2);
        drop_inputs();
        check_run(ARRAY_DIM);
        check_run(2);
    endtask

    // Junk words with in_valid high while the array is fed
    task automatic test_stray_strobe();
        fill_operands(ARRAY_DIM, 1'b1, '0);
        send_job(ARRAY_DIM);
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            in_valid    <= 1'b1;
            matrix      <= data_t'($urandom);
            matrix_size <= 1'($urandom);
        end
        drop_inputs();
        check_run(ARRAY_DIM);
    endtask

    initial begin
        int waited;
        in_valid    = 1'b0;
        matrix      = '0;
        matrix_size = 1'b0;
        void'($urandom(32'h4aaf));
        waited      = 0;
        while ((rst_n !== 1'b1) && (waited < 10)) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            other_errors++;
        end
        test_quiet_output();
        test_known_2x2();
        test_random_4x4();
        test_back_to_back();
        test_stray_strobe();
        // Any run left over came from no job
        if ((run_lens.size() != 0) || (got_values.size() != 0) || (run_len != 0)) begin
            $display("Found out_valid high outside the runs of the jobs sent");
            other_errors++;
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if ((value_errors + other_errors) == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== systolic_matmul.f ====
verilog/systolic_pkg.sv
verilog/operand_if.sv
verilog/operand_loader.sv
verilog/systolic_array.sv
verilog/diagonal_collector.sv
verilog/systolic_matmul.sv
testbench/tb_clock_gen.sv
testbench/systolic_matmul_asserts.sv
testbench/tb_systolic_matmul.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_systolic_matmul \
		-f systolic_matmul.f -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Test failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Test did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
